// File: all.f
frame_pkg.sv
sdram_bus_if.sv
video_timing.sv
cheat_injector.sv
sdram_bank.sv
cheat_frame_top.sv
tb_cheat_frame.sv

// File: cheat_frame_top.sv
/*
 * Top level of the cheat injection subsystem. Joins the video timing, the
 * injector and the memory bank; the game bus and cheat settings arrive as
 * plain ports and the two internal buses are bundled in sdram_bus_if.
 */
module cheat_frame_top import frame_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  enable,
    input  addr_t cheat_addr,
    input  word_t cheat_val,
    input  mask_t cheat_mask,
    input  addr_t game_addr,
    input  logic  game_rd,
    input  logic  game_wr,
    input  word_t game_din,
    input  mask_t game_din_m,
    output word_t game_dout,
    output logic  game_rdy,
    output logic  lvbl
);

    sdram_bus_if game_bus ();                       // game ports to injector
    sdram_bus_if bank_bus ();                       // injector to bank

    // game ports act as host of game_bus
    assign game_bus.addr  = game_addr;
    assign game_bus.rd    = game_rd;
    assign game_bus.wr    = game_wr;
    assign game_bus.din   = game_din;
    assign game_bus.din_m = game_din_m;
    assign game_dout      = game_bus.dout;
    assign game_rdy       = game_bus.rdy;

    video_timing u_timing (
        .clk  (clk),
        .rst  (rst),
        .lvbl (lvbl)                                // also feeds the injector below
    );

    cheat_injector u_injector (
        .clk        (clk),
        .rst        (rst),
        .lvbl       (lvbl),
        .enable     (enable),
        .cheat_addr (cheat_addr),
        .cheat_val  (cheat_val),
        .cheat_mask (cheat_mask),
        .game       (game_bus),
        .bank       (bank_bus)
    );

    sdram_bank u_bank (
        .clk (clk),
        .rst (rst),
        .bus (bank_bus)
    );

endmodule

// File: cheat_injector.sv
/*
 * Arbiter between the game and the bank. Game accesses pass straight through;
 * on every CHEAT_PERIOD-th falling edge of lvbl with enable high it waits for
 * the game bus to go idle and then issues one masked write of the cheat value.
 * The game sees no rdy while the cheat write owns the bank.
 */
module cheat_injector import frame_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      lvbl,
    input  logic      enable,
    input  addr_t     cheat_addr,
    input  word_t     cheat_val,
    input  mask_t     cheat_mask,
    sdram_bus_if.ctrl game,
    sdram_bus_if.host bank
);

    inj_state_t state;
    inj_state_t state_nx;
    frame_cnt_t frame_cnt;                          // frame phase inside the cheat period
    logic       lvbl_q;                             // lvbl one cycle back for edge detection
    logic       lvbl_fall;                          // start of vertical blank
    logic       game_req;                           // game shows rd or wr
    logic       lock;                               // cheat write owns the bank
    logic       cheat_due;                          // this blanking edge carries a cheat

    assign lvbl_fall = lvbl_q & ~lvbl;
    assign game_req  = game.rd | game.wr;
    assign lock      = state == INJECT;
    assign cheat_due = lvbl_fall && enable && frame_cnt == '0;

    // bank side mux, the game is substituted only during the cheat write
    always_comb begin
        if (lock) begin
            bank.addr  = cheat_addr;
            bank.rd    = 1'b0;                      // never read in a cheat slot
            bank.wr    = 1'b1;                      // held until the bank answers
            bank.din   = cheat_val;
            bank.din_m = cheat_mask;
        end else begin
            bank.addr  = game.addr;
            bank.rd    = game.rd;
            bank.wr    = game.wr;
            bank.din   = game.din;
            bank.din_m = game.din_m;
        end
    end

    assign game.dout = bank.dout;                   // read data is only meaningful with rdy
    assign game.rdy  = lock ? 1'b0 : bank.rdy;      // cheat completion is hidden from the game

    always_comb begin
        state_nx = state;
        case (state)
            PASS: begin
                if (cheat_due) begin
                    state_nx = WAIT_IDLE;           // wait for any open game access
                end
            end
            WAIT_IDLE: begin
                if (!game_req) begin
                    state_nx = INJECT;              // bus is free, take the bank
                end
            end
            INJECT: begin
                if (bank.rdy) begin
                    state_nx = PASS;                // held game request goes next cycle
                end
            end
            default: state_nx = PASS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= PASS;
            frame_cnt <= '0;
            lvbl_q    <= 1'b1;                      // matches lvbl after reset, no false edge
        end else begin
            state  <= state_nx;
            lvbl_q <= lvbl;
            if (lvbl_fall) begin
                // phase moves on every blanking edge, enabled or not
                frame_cnt <= (frame_cnt == frame_cnt_t'(CHEAT_PERIOD - 1)) ?
                             '0 : frame_cnt + 1'b1;
            end
        end
    end

endmodule

// File: frame_pkg.sv
/*
 * Shared widths, types and timing constants for the cheat injection subsystem.
 * Every RTL file and the testbench take these by wildcard import, so the frame
 * geometry, bank latency and cheat cadence are changed here and nowhere else.
 */
package frame_pkg;

    // memory geometry
    localparam int AW        = 10;                  // kept small so the whole bank can be modelled
    localparam int MEM_DEPTH = 1 << AW;              // words in the single bank

    typedef logic [AW-1:0] addr_t;                  // word address
    typedef logic [15:0]   word_t;                  // data word
    typedef logic [1:0]    mask_t;                  // byte mask, a set bit keeps that byte

    // video frame geometry in clocks and lines
    localparam int H_TOTAL  = 32;                   // clocks per line
    localparam int V_TOTAL  = 24;                   // lines per frame
    localparam int V_ACTIVE = 16;                   // visible lines, blanking follows

    typedef logic [$clog2(H_TOTAL)-1:0] hcnt_t;     // pixel position inside a line
    typedef logic [$clog2(V_TOTAL)-1:0] vcnt_t;     // line number inside a frame

    // cheat cadence
    localparam int CHEAT_PERIOD = 4;                // frames between two cheat writes

    typedef logic [$clog2(CHEAT_PERIOD)-1:0] frame_cnt_t; // frame phase in the cheat period

    // bank timing
    localparam int BANK_LAT = 3;                    // request to rdy distance, at least 2

    typedef logic [$clog2(BANK_LAT)-1:0] lat_cnt_t; // remaining busy cycles in the bank

    typedef enum logic {
        IDLE,                                       // waiting for rd or wr
        BUSY                                        // access accepted, latency running
    } bank_state_t;

    typedef enum logic [1:0] {
        PASS,                                       // game owns the bank
        WAIT_IDLE,                                  // cheat due, game access may still be open
        INJECT                                      // cheat write owns the bank
    } inj_state_t;

endpackage

// File: sdram_bank.sv
/*
 * Single-bank memory controller with a fixed access latency. A request seen in
 * IDLE is latched and answered BANK_LAT cycles later with a one-cycle rdy;
 * writes keep the bytes whose mask bit is set, reads present the word on dout.
 */
module sdram_bank import frame_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    sdram_bus_if.ctrl bus
);

    word_t       mem [MEM_DEPTH];                   // bank storage, contents undefined at start
    bank_state_t state;
    lat_cnt_t    lat_cnt;                           // cycles left before the answer
    addr_t       addr_q;                            // latched access
    word_t       din_q;
    mask_t       mask_q;
    logic        wr_q;                              // latched direction, high for a write
    logic        accept;                            // request taken this cycle
    logic        finish;                            // last busy cycle, answer on next edge
    word_t       wdata;                             // merged write word

    // a request still held in the rdy cycle belongs to the access just answered
    assign accept = state == IDLE && !bus.rdy && (bus.rd || bus.wr);
    assign finish = state == BUSY && lat_cnt == '0;

    // byte merge, a set mask bit keeps the stored byte
    always_comb begin
        wdata[15:8] = mask_q[1] ? mem[addr_q][15:8] : din_q[15:8];
        wdata[7:0]  = mask_q[0] ? mem[addr_q][7:0]  : din_q[7:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            lat_cnt <= '0;
            bus.rdy <= 1'b0;
        end else begin
            bus.rdy <= finish;                      // pulses BANK_LAT cycles after accept
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= BUSY;
                        lat_cnt <= lat_cnt_t'(BANK_LAT - 2);
                    end
                end
                BUSY: begin
                    if (finish) begin
                        state <= IDLE;              // idle in the rdy cycle already
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload path, latched on accept and used on the finishing edge
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= bus.addr;
            din_q  <= bus.din;
            mask_q <= bus.din_m;
            wr_q   <= bus.wr;
        end
        if (finish) begin
            if (wr_q) begin
                mem[addr_q] <= wdata;               // visible from the rdy cycle on
            end else begin
                bus.dout <= mem[addr_q];            // valid together with rdy
            end
        end
    end

endmodule

// File: sdram_bus_if.sv
/*
 * One request/ready memory bus. The host holds rd or wr with addr, din and
 * din_m until it sees the one-cycle rdy pulse; dout is valid with rdy on reads.
 * Used between the game ports and the injector, and between injector and bank.
 */
interface sdram_bus_if import frame_pkg::*; ();

    addr_t addr;                                    // word address of the access
    logic  rd;                                      // read request, held until rdy
    logic  wr;                                      // write request, held until rdy
    word_t din;                                     // write data
    mask_t din_m;                                   // write byte mask, set bit keeps byte
    word_t dout;                                    // read data, valid in the rdy cycle
    logic  rdy;                                     // one-cycle completion pulse

    // side that issues accesses
    modport host (
        output addr, rd, wr, din, din_m,
        input  dout, rdy
    );

    // side that serves accesses
    modport ctrl (
        input  addr, rd, wr, din, din_m,
        output dout, rdy
    );

endinterface

// File: tb_cheat_frame.sv
/*
 * Random-stimulus testbench for the cheat injection subsystem. Drives game
 * accesses on the top-level ports, tracks lvbl falls to know when a cheat is due,
 * and checks every read and latency against a reference memory model.
 */
module tb_cheat_frame import frame_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD    = 8;
    localparam int    ACCESS_LIMIT  = 4 * BANK_LAT + 8;    // cycles before an access counts as lost
    localparam int    TEST_FRAMES   = 28;                  // frames the whole sequence needs
    localparam int    MARGIN_FRAMES = 4;
    localparam int    WATCHDOG_NS   = (TEST_FRAMES + MARGIN_FRAMES) * V_TOTAL * H_TOTAL
                                      * CLK_PERIOD;
    localparam addr_t WIN_BASE      = 10'h040;             // random traffic window aligned to 16
    localparam int    WIN_SIZE      = 16;
    localparam addr_t CHEAT_A       = 10'h2c7;             // outside the random window

    logic  clk;
    logic  rst;
    logic  enable;
    addr_t cheat_addr;
    word_t cheat_val;
    mask_t cheat_mask;
    addr_t game_addr;
    logic  game_rd;
    logic  game_wr;
    word_t game_din;
    mask_t game_din_m;
    word_t game_dout;
    logic  game_rdy;
    logic  lvbl;

    word_t  model_mem [MEM_DEPTH];                          // reference copy of the bank
    integer seed = 32'h37b4_3438;
    int     errors = 0;
    int     checks = 0;
    int     fall_cnt = 0;                                   // lvbl falls seen since reset
    int     cheats_due = 0;                                 // injecting falls seen by the monitor
    int     cheats_applied = 0;                             // injecting falls already in the model

    cheat_frame_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every falling lvbl is a frame edge and each CHEAT_PERIOD-th one with enable high injects
    initial begin
        forever begin
            @(negedge lvbl);
            @(posedge clk);                                 // the injector decides on this edge
            if (fall_cnt % CHEAT_PERIOD == 0 && enable) begin
                cheats_due++;
            end
            fall_cnt++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test sequence did not finish, %0d errors so far", errors);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // a set mask bit keeps the stored byte and bit 1 is the upper byte
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, mask_t m);
        word_t r;
        r[15:8] = m[1] ? old_w[15:8] : new_w[15:8];
        r[7:0]  = m[0] ? old_w[7:0]  : new_w[7:0];
        return r;
    endfunction

    task automatic apply_pending();
        while (cheats_applied < cheats_due) begin
            model_mem[cheat_addr] = merge_bytes(model_mem[cheat_addr], cheat_val, cheat_mask);
            cheats_applied++;
        end
    endtask

    // blanking lasts far longer than one cheat write, so once lvbl is high again it has landed
    task automatic wait_active();
        while (!lvbl) begin
            @(posedge clk);
            #1;
        end
        apply_pending();
    endtask

    task automatic wait_fall();
        int start;
        start = fall_cnt;
        while (fall_cnt == start) begin
            @(posedge clk);
            #1;
        end
    endtask

    // park until the next lvbl fall is an injecting one
    task automatic seek_inject_phase();
        while (fall_cnt % CHEAT_PERIOD != 0) begin
            wait_fall();
        end
    endtask

    // one game access raised a cycle after the call and held until game_rdy
    task automatic access(input string name, input logic write, input addr_t a, input word_t d,
                          input mask_t m, output word_t q, output int lat);
        word_t expected;
        @(posedge clk);
        #1;
        expected   = model_mem[a];
        game_addr  = a;
        game_rd    = !write;
        game_wr    = write;
        game_din   = d;
        game_din_m = m;
        @(posedge clk);
        #1;
        lat = 1;
        while (!game_rdy && lat < ACCESS_LIMIT) begin
            @(posedge clk);
            #1;
            lat++;
        end
        q       = game_dout;                                // dout is valid with rdy
        game_rd = 1'b0;
        game_wr = 1'b0;
        if (!game_rdy) begin
            errors++;
            $display("%s: access to address %0h got no game_rdy in %0d cycles", name, a, lat);
        end else if (write) begin
            model_mem[a] = merge_bytes(model_mem[a], d, m);
        end else begin
            check(name, expected, q);
        end
    endtask

    task automatic random_traffic(input string name, input int n);
        addr_t a;
        word_t q;
        logic  wr;
        int    lat;
        for (int i = 0; i < n; i++) begin
            wait_active();
            a  = WIN_BASE + addr_t'($random(seed) & (WIN_SIZE - 1));
            wr = ($random(seed) & 1) != 0;
            access(name, wr, a, word_t'($random(seed)), mask_t'($random(seed)), q, lat);
            check({name, " latency"}, BANK_LAT, lat);       // no injection can overlap here
        end
    endtask

    initial begin
        word_t q;
        word_t g;
        int    lat;
        int    n;
        rst        = 1'b1;
        enable     = 1'b0;
        cheat_addr = CHEAT_A;
        cheat_val  = '0;
        cheat_mask = '0;
        game_addr  = '0;
        game_rd    = 1'b0;
        game_wr    = 1'b0;
        game_din   = '0;
        game_din_m = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // b1 reset state and first frame edge
        check("b1 game_rdy after reset", 0, game_rdy);
        check("b1 lvbl after reset", 1, lvbl);
        n = 0;
        while (lvbl && n < V_TOTAL * H_TOTAL) begin
            @(posedge clk);
            #1;
            n++;
        end
        check("b1 first lvbl fall", V_ACTIVE * H_TOTAL, n);

        // b2 plain traffic with injection off and the window filled before any read
        for (int i = 0; i < WIN_SIZE; i++) begin
            wait_active();
            access("b2 fill", 1'b1, WIN_BASE + addr_t'(i), word_t'($random(seed)), 2'b00, q, lat);
        end
        random_traffic("b2 random", 200);

        // b3 full-word cheat against game writes at the same address
        wait_active();
        cheat_val  = word_t'($random(seed));
        cheat_mask = 2'b00;
        enable     = 1'b1;
        access("b3 game write", 1'b1, CHEAT_A, ~cheat_val, 2'b00, q, lat);
        seek_inject_phase();
        wait_fall();
        wait_active();
        access("b3 read after cheat", 1'b0, CHEAT_A, '0, '0, q, lat);
        check("b3 cheat landed", cheat_val, q);
        g = cheat_val ^ 16'h5a3c;                            // differs from the cheat in both bytes
        access("b3 game overwrite", 1'b1, CHEAT_A, g, 2'b00, q, lat);
        for (int k = 1; k < CHEAT_PERIOD; k++) begin
            wait_fall();
            wait_active();
            access("b3 read idle frame", 1'b0, CHEAT_A, '0, '0, q, lat);
            check("b3 game value kept", g, q);
        end
        wait_fall();
        wait_active();
        access("b3 read next cheat", 1'b0, CHEAT_A, '0, '0, q, lat);
        check("b3 cheat back", cheat_val, q);

        // b4 upper byte kept by the cheat mask
        wait_active();
        cheat_val  = word_t'($random(seed));
        cheat_mask = 2'b10;
        g          = ~cheat_val;                             // differs from the cheat in both bytes
        access("b4 game write", 1'b1, CHEAT_A, g, 2'b00, q, lat);
        seek_inject_phase();
        wait_fall();
        wait_active();
        access("b4 read after cheat", 1'b0, CHEAT_A, '0, '0, q, lat);
        check("b4 masked cheat", {g[15:8], cheat_val[7:0]}, q);

        // b5 game write raised two cycles after an injecting fall waits for the cheat
        wait_active();
        cheat_val  = word_t'($random(seed));
        cheat_mask = 2'b00;
        seek_inject_phase();
        wait_fall();
        access("b5 stalled write", 1'b1, WIN_BASE + 5, word_t'($random(seed)), 2'b00, q, lat);
        check("b5 write stalled", 1, lat > BANK_LAT);
        check("b5 stall bound", 1, lat <= 2 * BANK_LAT + 1);
        apply_pending();                                     // cheat finished before the stalled write
        access("b5 read cheat", 1'b0, CHEAT_A, '0, '0, q, lat);
        check("b5 cheat value", cheat_val, q);
        access("b5 read stalled write", 1'b0, WIN_BASE + 5, '0, '0, q, lat);

        // b6 injection off again so the game value must stay for several periods
        wait_active();
        enable = 1'b0;
        g      = word_t'($random(seed));
        access("b6 game write", 1'b1, CHEAT_A, g, 2'b00, q, lat);
        repeat (2 * CHEAT_PERIOD) begin
            wait_fall();
            wait_active();
            access("b6 read", 1'b0, CHEAT_A, '0, '0, q, lat);
            check("b6 no cheat", g, q);
        end

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: video_timing.sv
/*
 * Video timing generator for the frame cadence. Runs a pixel and a line counter
 * and produces the active-low vertical blank lvbl, registered so that it
 * changes exactly on the first clock of line V_ACTIVE and of line 0.
 */
module video_timing import frame_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic lvbl
);

    hcnt_t hcnt;                                    // pixel counter
    vcnt_t vcnt;                                    // line counter
    hcnt_t hcnt_nx;
    vcnt_t vcnt_nx;
    logic  line_end;                                // last clock of the current line
    logic  frame_end;                               // last line of the frame

    assign line_end  = hcnt == hcnt_t'(H_TOTAL - 1);
    assign frame_end = vcnt == vcnt_t'(V_TOTAL - 1);

    // next counter values, also used to register lvbl in step with vcnt
    always_comb begin
        hcnt_nx = line_end ? '0 : hcnt + 1'b1;     // pixels wrap every line
        vcnt_nx = vcnt;                             // lines only move at a line end
        if (line_end) begin
            vcnt_nx = frame_end ? '0 : vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
            lvbl <= 1'b1;                           // frame starts on a visible line
        end else begin
            hcnt <= hcnt_nx;
            vcnt <= vcnt_nx;
            // high on the visible lines, low through the blanking lines
            lvbl <= vcnt_nx < vcnt_t'(V_ACTIVE);
        end
    end

endmodule
